//--- team_01_pkg.sv
/*
 * Shared types and defaults for the keypad-to-LCD subsystem
 * Bus request, LCD transfer and key report structs, controller states,
 * keypad ASCII table and default timing values
 */
`default_nettype none

package team_01_pkg;

   // Single Wishbone request from the controller, 69 bits
   typedef struct packed {
      logic [31:0] adr;
      logic [31:0] dat;
      logic [3:0]  sel;
      logic        we;
   } wb_req_t;

   // One LCD transfer, rs then data byte
   typedef struct packed {
      logic       rs;
      logic [7:0] data;
   } lcd_cmd_t;

   // Keypad position
   typedef struct packed {
      logic [1:0] row;
      logic [1:0] col;
   } key_t;

   typedef enum logic [2:0] {
      IDLE,
      WR_REQ,
      WR_WAIT,
      RD_REQ,
      RD_WAIT,
      SHOW,
      SHOW_WAIT,
      CLEAR
   } ctl_state_e;

   // Indexed by row*4 + col
   localparam logic [7:0] KEY_ASCII [16] = '{
      "1", "2", "3", "A",
      "4", "5", "6", "B",
      "7", "8", "9", "C",
      "*", "0", "#", "D"
   };

   // HD44780 clear display, sent with rs low
   localparam logic [7:0] LCD_CLEAR_CMD = 8'h01;

   // Default values for the top level parameters
   localparam logic [31:0] LOG_BASE         = 32'h3000_0000;
   localparam int          SCAN_CYCLES      = 4;
   localparam int          DEBOUNCE_SCANS   = 2;
   localparam int          LCD_PULSE_CYCLES = 3;

endpackage

`default_nettype wire

//--- wishbone_manager.sv
/*
 * Wishbone classic manager
 * Turns one-cycle read/write pulses into single bus cycles held until ACK,
 * captures read data and reports busy to the controller
 */
`default_nettype none
`timescale 1ns/1ps

module wishbone_manager (
   input  logic                 clk,
   input  logic                 rst_n_i,
   input  team_01_pkg::wb_req_t req_i,
   input  logic                 write_i,
   input  logic                 read_i,
   input  logic [31:0]          dat_i,
   input  logic                 ack_i,
   output logic [31:0]          adr_o,
   output logic [31:0]          dat_o,
   output logic [3:0]           sel_o,
   output logic                 we_o,
   output logic                 stb_o,
   output logic                 cyc_o,
   output logic [31:0]          rd_data_o,
   output logic                 busy_o
);

   typedef enum logic {
      WB_IDLE,
      WB_CYCLE
   } wb_state_e;

   wb_state_e state_q;
   logic      start;

   assign start = (state_q == WB_IDLE) && (write_i || read_i);

   // Busy rises with the request pulse itself
   assign busy_o = (state_q == WB_CYCLE) || write_i || read_i;

   // Control and strobes
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= WB_IDLE;
         stb_o   <= 1'b0;
         cyc_o   <= 1'b0;
         we_o    <= 1'b0;
         sel_o   <= 4'b0000;
      end else begin
         case (state_q)
            WB_IDLE: begin
               if (start) begin
                  state_q <= WB_CYCLE;
                  stb_o   <= 1'b1;
                  cyc_o   <= 1'b1;
                  we_o    <= req_i.we;
                  sel_o   <= req_i.sel;
               end
            end
            WB_CYCLE: begin
               // Wait states stretch the cycle
               if (ack_i) begin
                  state_q <= WB_IDLE;
                  stb_o   <= 1'b0;
                  cyc_o   <= 1'b0;
                  we_o    <= 1'b0;
                  sel_o   <= 4'b0000;
               end
            end
            default: state_q <= WB_IDLE;
         endcase
      end
   end

   // Address, write data and read data
   always_ff @(posedge clk) begin
      if (start) begin
         adr_o <= req_i.adr;
         dat_o <= req_i.dat;
      end
      if ((state_q == WB_CYCLE) && ack_i && !we_o) begin
         rd_data_o <= dat_i;
      end
   end

   // STB and CYC move together
   a_stb_cyc : assert property (@(posedge clk) disable iff (!rst_n_i)
      stb_o == cyc_o);

   // Everything held while the target stalls
   a_stall_hold : assert property (@(posedge clk) disable iff (!rst_n_i)
      (stb_o && !ack_i) |=> (stb_o && $stable({adr_o, dat_o, sel_o, we_o})));

endmodule

`default_nettype wire

//--- keypad_scanner.sv
/*
 * 4x4 keypad scanner
 * Drives one column at a time, samples the rows at the end of each column,
 * debounces over full scans and reports each press once
 */
`default_nettype none
`timescale 1ns/1ps

module keypad_scanner #(
   parameter int SCAN_CYCLES    = team_01_pkg::SCAN_CYCLES,
   parameter int DEBOUNCE_SCANS = team_01_pkg::DEBOUNCE_SCANS
) (
   input  logic              clk,
   input  logic              rst_n_i,
   input  logic              en_i,
   input  logic [3:0]        rows_i,
   output logic [3:0]        cols_o,
   output logic              key_valid_o,
   output team_01_pkg::key_t key_o
);
   import team_01_pkg::*;

   localparam int CW = (SCAN_CYCLES > 1) ? $clog2(SCAN_CYCLES) : 1;
   localparam int MW = $clog2(DEBOUNCE_SCANS + 1);

   logic          active_q;
   logic [CW-1:0] dwell_q;
   logic [1:0]    col_q;
   logic          last_dwell;
   logic          scan_end;
   logic [1:0]    row_idx;
   logic          scan_hit_q;
   key_t          scan_key_q;
   key_t          last_key_q;
   logic          cur_hit;
   key_t          cur_key;
   logic [MW-1:0] match_q;
   logic [MW-1:0] match_d;
   logic          armed_q;

   // Columns low out of reset and while disabled
   assign cols_o = active_q ? (4'b0001 << col_q) : 4'b0000;

   assign last_dwell = active_q && (dwell_q == CW'(SCAN_CYCLES - 1));
   assign scan_end   = last_dwell && (col_q == 2'd3);

   // Lowest row wins
   always_comb begin
      row_idx = 2'd0;
      for (int r = 3; r >= 0; r--) begin
         if (rows_i[r]) begin
            row_idx = 2'(r);
         end
      end
   end

   // First hit of this scan, including the column now sampled
   assign cur_hit = scan_hit_q || (|rows_i);
   assign cur_key = scan_hit_q ? scan_key_q : '{row: row_idx, col: col_q};

   // Run length of the same key over full scans, saturating
   always_comb begin
      if (!cur_hit) begin
         match_d = '0;
      end else if ((match_q != '0) && (cur_key == last_key_q)) begin
         match_d = (match_q == MW'(DEBOUNCE_SCANS)) ? match_q : match_q + 1'b1;
      end else begin
         match_d = MW'(1);
      end
   end

   assign key_o = last_key_q;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         active_q    <= 1'b0;
         dwell_q     <= '0;
         col_q       <= 2'd0;
         scan_hit_q  <= 1'b0;
         match_q     <= '0;
         armed_q     <= 1'b1;
         key_valid_o <= 1'b0;
      end else begin
         active_q    <= en_i;
         key_valid_o <= 1'b0;
         if (active_q) begin
            dwell_q <= last_dwell ? '0 : dwell_q + 1'b1;
            if (last_dwell) begin
               col_q <= col_q + 2'd1;
            end
         end
         if (last_dwell && !scan_end) begin
            scan_hit_q <= cur_hit;
         end
         if (scan_end) begin
            scan_hit_q <= 1'b0;
            match_q    <= match_d;
            // An empty scan re-arms the next report
            if (!cur_hit) begin
               armed_q <= 1'b1;
            end else if (armed_q && (match_d == MW'(DEBOUNCE_SCANS))) begin
               armed_q     <= 1'b0;
               key_valid_o <= 1'b1;
            end
         end
      end
   end

   // Key payload
   always_ff @(posedge clk) begin
      if (last_dwell && !scan_end && !scan_hit_q) begin
         scan_key_q <= cur_key;
      end
      if (scan_end && cur_hit) begin
         last_key_q <= cur_key;
      end
   end

   a_cols_onehot : assert property (@(posedge clk) disable iff (!rst_n_i)
      $onehot0(cols_o));

endmodule

`default_nettype wire

//--- lcd_driver.sv
/*
 * HD44780-style 8-bit LCD write driver
 * Latches rs and data on a strobe and times the enable pulse and the
 * recovery gap before the next transfer
 */
`default_nettype none
`timescale 1ns/1ps

module lcd_driver #(
   parameter int LCD_PULSE_CYCLES = team_01_pkg::LCD_PULSE_CYCLES
) (
   input  logic                  clk,
   input  logic                  rst_n_i,
   input  team_01_pkg::lcd_cmd_t cmd_i,
   input  logic                  strobe_i,
   output logic                  ready_o,
   output logic                  lcd_en_o,
   output logic                  lcd_rs_o,
   output logic [7:0]            lcd_data_o
);
   import team_01_pkg::*;

   localparam int PW = (LCD_PULSE_CYCLES > 1) ? $clog2(LCD_PULSE_CYCLES) : 1;

   typedef enum logic [1:0] {
      L_IDLE,
      L_SETUP,
      L_PULSE,
      L_RECOVER
   } lcd_state_e;

   lcd_state_e    state_q;
   logic [PW-1:0] cnt_q;
   logic          cnt_done;
   lcd_cmd_t      cmd_q;

   assign cnt_done = (cnt_q == PW'(LCD_PULSE_CYCLES - 1));

   assign ready_o    = (state_q == L_IDLE);
   assign lcd_en_o   = (state_q == L_PULSE);
   assign lcd_rs_o   = cmd_q.rs;
   assign lcd_data_o = cmd_q.data;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= L_IDLE;
         cnt_q   <= '0;
         cmd_q   <= '0;
      end else begin
         case (state_q)
            L_IDLE: begin
               // Pins settle one cycle ahead of en
               if (strobe_i) begin
                  cmd_q   <= cmd_i;
                  state_q <= L_SETUP;
               end
            end
            L_SETUP: begin
               cnt_q   <= '0;
               state_q <= L_PULSE;
            end
            L_PULSE: begin
               if (cnt_done) begin
                  cnt_q   <= '0;
                  state_q <= L_RECOVER;
               end else begin
                  cnt_q <= cnt_q + 1'b1;
               end
            end
            L_RECOVER: begin
               // rs and data still held here
               if (cnt_done) begin
                  cnt_q   <= '0;
                  state_q <= L_IDLE;
               end else begin
                  cnt_q <= cnt_q + 1'b1;
               end
            end
            default: state_q <= L_IDLE;
         endcase
      end
   end

   a_strobe_ready : assert property (@(posedge clk) disable iff (!rst_n_i)
      strobe_i |-> ready_o);

endmodule

`default_nettype wire

//--- team_01_cpu.sv
/*
 * Per-key sequencer
 * Logs each key to memory, reads it back and shows the returned byte,
 * or clears the display and the log index on the star key
 */
`default_nettype none
`timescale 1ns/1ps

module team_01_cpu #(
   parameter logic [31:0] LOG_BASE = team_01_pkg::LOG_BASE
) (
   input  logic                  clk,
   input  logic                  rst_n_i,
   input  logic                  en_i,
   input  logic                  key_valid_i,
   input  team_01_pkg::key_t     key_i,
   input  logic                  busy_i,
   input  logic [31:0]           rd_data_i,
   input  logic                  lcd_ready_i,
   output team_01_pkg::wb_req_t  req_o,
   output logic                  write_o,
   output logic                  read_o,
   output team_01_pkg::lcd_cmd_t lcd_cmd_o,
   output logic                  lcd_strobe_o
);
   import team_01_pkg::*;

   ctl_state_e  state_q;
   ctl_state_e  state_d;
   logic [29:0] idx_q;
   wb_req_t     req_q;
   logic [7:0]  key_code;
   logic        is_clear;
   logic        key_take;
   logic        wr_done;

   assign key_code = KEY_ASCII[{key_i.row, key_i.col}];
   assign is_clear = (key_code == "*");

   // Keys outside IDLE are dropped
   assign key_take = (state_q == IDLE) && key_valid_i && en_i && !busy_i;
   assign wr_done  = (state_q == WR_WAIT) && !busy_i;

   // Request pulses come from state only, busy is only watched while waiting
   assign write_o      = (state_q == WR_REQ);
   assign read_o       = (state_q == RD_REQ);
   assign lcd_strobe_o = ((state_q == SHOW) || (state_q == CLEAR)) && lcd_ready_i;
   assign req_o        = req_q;

   always_comb begin
      if (state_q == CLEAR) begin
         lcd_cmd_o = '{rs: 1'b0, data: LCD_CLEAR_CMD};
      end else begin
         // Read-back byte, not the key code
         lcd_cmd_o = '{rs: 1'b1, data: rd_data_i[7:0]};
      end
   end

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE:      if (key_take) state_d = is_clear ? CLEAR : WR_REQ;
         WR_REQ:    state_d = WR_WAIT;
         WR_WAIT:   if (!busy_i) state_d = RD_REQ;
         RD_REQ:    state_d = RD_WAIT;
         RD_WAIT:   if (!busy_i) state_d = SHOW;
         SHOW:      if (lcd_ready_i) state_d = SHOW_WAIT;
         CLEAR:     if (lcd_ready_i) state_d = SHOW_WAIT;
         // Back to IDLE once the LCD has recovered
         SHOW_WAIT: if (lcd_ready_i) state_d = IDLE;
         default:   state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= IDLE;
         idx_q   <= '0;
      end else begin
         state_q <= state_d;
         if (wr_done) begin
            idx_q <= idx_q + 30'd1;
         end else if ((state_q == CLEAR) && lcd_ready_i) begin
            idx_q <= '0;
         end
      end
   end

   // Word address from the index, byte lane 0 only
   always_ff @(posedge clk) begin
      if (key_take) begin
         req_q.adr <= LOG_BASE + {idx_q, 2'b00};
         req_q.dat <= {24'h0, key_code};
         req_q.sel <= 4'b0001;
         req_q.we  <= 1'b1;
      end else if (wr_done) begin
         // Same address, now a read
         req_q.we <= 1'b0;
      end
   end

   // LCD strobes never overlap a bus cycle
   a_no_show_on_bus : assert property (@(posedge clk) disable iff (!rst_n_i)
      lcd_strobe_o |-> !busy_i);

endmodule

`default_nettype wire

//--- team_01.sv
/*
 * Team wrapper for the user project area
 * Connects keypad scanner, sequencer, LCD driver and Wishbone manager
 * to the GPIO pins, the logic analyzer and the Wishbone bus
 */
`default_nettype none
`timescale 1ns/1ps

module team_01 #(
   parameter int          SCAN_CYCLES      = team_01_pkg::SCAN_CYCLES,
   parameter int          DEBOUNCE_SCANS   = team_01_pkg::DEBOUNCE_SCANS,
   parameter int          LCD_PULSE_CYCLES = team_01_pkg::LCD_PULSE_CYCLES,
   parameter logic [31:0] LOG_BASE         = team_01_pkg::LOG_BASE
) (
   input  logic         clk,
   input  logic         rst_n_i,
   // Chip enable, low stops scanning and new sequences
   input  logic         en_i,
   input  logic [127:0] la_data_in_i,
   output logic [127:0] la_data_out_o,
   input  logic [127:0] la_oenb_i,
   input  logic [33:0]  gpio_in_i,
   output logic [33:0]  gpio_out_o,
   // Active low output enables
   output logic [33:0]  gpio_oeb_o,
   input  logic [31:0]  dat_i,
   input  logic         ack_i,
   output logic [31:0]  adr_o,
   output logic [31:0]  dat_o,
   output logic [3:0]   sel_o,
   output logic         we_o,
   output logic         stb_o,
   output logic         cyc_o
);
   import team_01_pkg::*;

   wb_req_t     wb_req;
   logic        wb_write;
   logic        wb_read;
   logic        wb_busy;
   logic [31:0] wb_rd_data;
   logic        key_valid;
   key_t        key;
   lcd_cmd_t    lcd_cmd;
   logic        lcd_strobe;
   logic        lcd_ready;
   logic        lcd_en;
   logic        lcd_rs;
   logic [7:0]  lcd_data;
   logic [3:0]  cols;

   // LA not used by this design
   assign la_data_out_o = 128'b0;

   // 33:20 spare, 19:16 cols, 15:12 rows, 11:4 data, 3 rw, 2 rs, 1 en, 0 spare
   assign gpio_out_o = {14'b0, cols, 4'b0000, lcd_data, 1'b0, lcd_rs, lcd_en, 1'b0};
   assign gpio_oeb_o = {{14{1'b1}}, 4'b0000, 4'b1111, 8'b0, 4'b0000};

   wishbone_manager i_wishbone_manager (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .req_i     (wb_req),
      .write_i   (wb_write),
      .read_i    (wb_read),
      .dat_i     (dat_i),
      .ack_i     (ack_i),
      .adr_o     (adr_o),
      .dat_o     (dat_o),
      .sel_o     (sel_o),
      .we_o      (we_o),
      .stb_o     (stb_o),
      .cyc_o     (cyc_o),
      .rd_data_o (wb_rd_data),
      .busy_o    (wb_busy)
   );

   keypad_scanner #(
      .SCAN_CYCLES    (SCAN_CYCLES),
      .DEBOUNCE_SCANS (DEBOUNCE_SCANS)
   ) i_keypad_scanner (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .en_i        (en_i),
      .rows_i      (gpio_in_i[15:12]),
      .cols_o      (cols),
      .key_valid_o (key_valid),
      .key_o       (key)
   );

   lcd_driver #(
      .LCD_PULSE_CYCLES (LCD_PULSE_CYCLES)
   ) i_lcd_driver (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .cmd_i      (lcd_cmd),
      .strobe_i   (lcd_strobe),
      .ready_o    (lcd_ready),
      .lcd_en_o   (lcd_en),
      .lcd_rs_o   (lcd_rs),
      .lcd_data_o (lcd_data)
   );

   team_01_cpu #(
      .LOG_BASE (LOG_BASE)
   ) i_team_01_cpu (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .en_i         (en_i),
      .key_valid_i  (key_valid),
      .key_i        (key),
      .busy_i       (wb_busy),
      .rd_data_i    (wb_rd_data),
      .lcd_ready_i  (lcd_ready),
      .req_o        (wb_req),
      .write_o      (wb_write),
      .read_o       (wb_read),
      .lcd_cmd_o    (lcd_cmd),
      .lcd_strobe_o (lcd_strobe)
   );

endmodule

`default_nettype wire

//--- tb_checker.sv
/*
 * Scoreboard for the keypad-to-LCD testbench
 * Captures acknowledged bus cycles and LCD transfers and compares them
 * in order with the expected events pushed by the stimulus loop
 */
`default_nettype none
`timescale 1ns/1ps

module tb_checker (
   input  logic         clk,
   input  logic         rst_n_i,
   input  logic         en_i,
   input  logic         stb_i,
   input  logic         cyc_i,
   input  logic         ack_i,
   input  logic         we_i,
   input  logic [31:0]  adr_i,
   input  logic [31:0]  dat_i,
   input  logic [3:0]   sel_i,
   input  logic         lcd_en_i,
   input  logic         lcd_rs_i,
   input  logic [7:0]   lcd_data_i,
   input  logic [3:0]   cols_i,
   input  logic [127:0] la_out_i,
   input  logic [33:0]  gpio_out_i,
   input  logic [33:0]  gpio_oeb_i,
   output int           err_count_o,
   output int           bus_count_o,
   output int           lcd_count_o
);
   import team_01_pkg::*;

   // Expected bus cycle where data only matters on writes
   typedef struct packed {
      logic        we;
      logic [31:0] adr;
      logic [7:0]  dat;
   } bus_ev_t;

   bus_ev_t  bus_q[$];
   lcd_cmd_t lcd_q[$];
   bus_ev_t  exp_bus;
   lcd_cmd_t exp_lcd;
   logic     stb_prev;
   logic     ack_prev;
   logic     en_prev;
   logic     lcd_en_prev;
   logic     pins_flagged;

   initial begin
      err_count_o  = 0;
      bus_count_o  = 0;
      lcd_count_o  = 0;
      pins_flagged = 1'b0;
   end

   task automatic push_bus(input logic we, input logic [31:0] adr, input logic [7:0] dat);
      bus_q.push_back('{we: we, adr: adr, dat: dat});
   endtask

   task automatic push_lcd(input logic rs, input logic [7:0] data);
      lcd_q.push_back('{rs: rs, data: data});
   endtask

   task automatic flag_error(input string msg);
      $display("[FAIL] %0d ns: %s", $time, msg);
      err_count_o++;
   endtask

   // Anything still queued was never seen on the pins
   task automatic final_check();
      if (bus_q.size() != 0) begin
         $display("Missing %0d expected bus cycles at end of run", bus_q.size());
         err_count_o += bus_q.size();
      end
      if (lcd_q.size() != 0) begin
         $display("Missing %0d expected LCD transfers at end of run", lcd_q.size());
         err_count_o += lcd_q.size();
      end
   endtask

   always @(posedge clk) begin
      if (rst_n_i) begin
         // Acknowledged bus cycle
         if (stb_i && cyc_i && ack_i) begin
            bus_count_o++;
            if (bus_q.size() == 0) begin
               flag_error($sformatf("unexpected bus cycle to %h", adr_i));
            end else begin
               exp_bus = bus_q.pop_front();
               if ((we_i !== exp_bus.we) || (adr_i !== exp_bus.adr)) begin
                  flag_error($sformatf("bus we=%b adr=%h, expected we=%b adr=%h",
                     we_i, adr_i, exp_bus.we, exp_bus.adr));
               end else if (exp_bus.we &&
                  ((dat_i !== {24'h0, exp_bus.dat}) || (sel_i !== 4'b0001))) begin
                  flag_error($sformatf("write data %h sel %b, expected %h sel 0001",
                     dat_i, sel_i, exp_bus.dat));
               end
            end
         end
         // Classic cycle must hold until ACK
         if (stb_prev && !ack_prev && !stb_i) begin
            flag_error("STB dropped before ACK");
         end
         // LCD latches rs and data on the falling edge of en
         if (lcd_en_prev && !lcd_en_i) begin
            lcd_count_o++;
            if (lcd_q.size() == 0) begin
               flag_error($sformatf("unexpected LCD transfer rs=%b data=%h",
                  lcd_rs_i, lcd_data_i));
            end else begin
               exp_lcd = lcd_q.pop_front();
               if ((lcd_rs_i !== exp_lcd.rs) || (lcd_data_i !== exp_lcd.data)) begin
                  flag_error($sformatf("LCD rs=%b data=%h, expected rs=%b data=%h",
                     lcd_rs_i, lcd_data_i, exp_lcd.rs, exp_lcd.data));
               end
            end
         end
         // Scanner lags en by one cycle
         if (!en_i && !en_prev && (cols_i != 4'b0000)) begin
            flag_error($sformatf("columns %b driven while disabled", cols_i));
         end
         // Tied outputs, and rows as the only inputs among pins 1 to 19
         if (!pins_flagged && ((la_out_i !== 128'b0) || (gpio_out_i[3] !== 1'b0) ||
            (gpio_out_i[0] !== 1'b0) || (gpio_out_i[33:20] !== 14'b0) ||
            (gpio_oeb_i[19:1] !== {4'b0000, 4'b1111, 11'b0}))) begin
            pins_flagged = 1'b1;
            flag_error($sformatf("fixed pins wrong, la_out=%h gpio_out=%h gpio_oeb=%h",
               la_out_i, gpio_out_i, gpio_oeb_i));
         end
      end
      stb_prev    <= rst_n_i && stb_i;
      ack_prev    <= rst_n_i && ack_i;
      en_prev     <= en_i;
      lcd_en_prev <= rst_n_i && lcd_en_i;
   end

endmodule

`default_nettype wire

//--- tb_team_01.sv
/*
 * Testbench for the team_01 keypad-to-LCD subsystem
 * Keypad and Wishbone memory models, stimulus table run in a loop,
 * scoreboard instance and run timeout
 */
`default_nettype none
`timescale 1ns/1ps

module tb_team_01;
   import team_01_pkg::*;

   localparam int SCAN     = team_01_pkg::SCAN_CYCLES;
   localparam int NSTEP    = 10;

   // One table row with key, enable, timing in scans and expected events
   typedef struct packed {
      logic        pressed;
      logic [3:0]  key;
      logic        en;
      logic [3:0]  hold;
      logic [3:0]  rel;
      logic        has_bus;
      logic [31:0] adr;
      logic [7:0]  dat;
      logic        has_lcd;
      logic        rs;
      logic [7:0]  lcd;
      logic        corrupt;
   } stim_t;

   logic         clk;
   logic         rst_n_i;
   logic         en_i;
   logic [127:0] la_data_in;
   logic [127:0] la_data_out;
   logic [127:0] la_oenb;
   logic [33:0]  gpio_in;
   logic [33:0]  gpio_out;
   logic [33:0]  gpio_oeb;
   logic [31:0]  wb_dat_i;
   logic         ack_i;
   logic [31:0]  adr;
   logic [31:0]  wb_dat_o;
   logic [3:0]   sel;
   logic         we;
   logic         stb;
   logic         cyc;
   logic         key_down;
   logic [3:0]   held_key;
   logic [3:0]   rows;
   logic         corrupt;
   logic [31:0]  mem [64];
   logic         in_cycle;
   int           wait_left;
   int           err_count;
   int           bus_count;
   int           lcd_count;
   int           cycles;
   int           limit;
   int           lcd_expected;
   stim_t        steps [NSTEP];
   stim_t        s;

   team_01 #(
      .SCAN_CYCLES      (SCAN),
      .DEBOUNCE_SCANS   (team_01_pkg::DEBOUNCE_SCANS),
      .LCD_PULSE_CYCLES (team_01_pkg::LCD_PULSE_CYCLES),
      .LOG_BASE         (team_01_pkg::LOG_BASE)
   ) i_team_01 (
      .clk           (clk),
      .rst_n_i       (rst_n_i),
      .en_i          (en_i),
      .la_data_in_i  (la_data_in),
      .la_data_out_o (la_data_out),
      .la_oenb_i     (la_oenb),
      .gpio_in_i     (gpio_in),
      .gpio_out_o    (gpio_out),
      .gpio_oeb_o    (gpio_oeb),
      .dat_i         (wb_dat_i),
      .ack_i         (ack_i),
      .adr_o         (adr),
      .dat_o         (wb_dat_o),
      .sel_o         (sel),
      .we_o          (we),
      .stb_o         (stb),
      .cyc_o         (cyc)
   );

   tb_checker i_checker (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .en_i        (en_i),
      .stb_i       (stb),
      .cyc_i       (cyc),
      .ack_i       (ack_i),
      .we_i        (we),
      .adr_i       (adr),
      .dat_i       (wb_dat_o),
      .sel_i       (sel),
      .lcd_en_i    (gpio_out[1]),
      .lcd_rs_i    (gpio_out[2]),
      .lcd_data_i  (gpio_out[11:4]),
      .cols_i      (gpio_out[19:16]),
      .la_out_i    (la_data_out),
      .gpio_out_i  (gpio_out),
      .gpio_oeb_i  (gpio_oeb),
      .err_count_o (err_count),
      .bus_count_o (bus_count),
      .lcd_count_o (lcd_count)
   );

   always #2 clk = ~clk;

   // Held key shorts its column onto its row
   always_comb begin
      rows = 4'b0000;
      if (key_down) begin
         rows[held_key[3:2]] = gpio_out[16 + held_key[1:0]];
      end
   end
   assign gpio_in = {18'b0, rows, 12'b0};

   // Memory with 0 to 3 random wait states per cycle
   always @(posedge clk) begin
      #1;
      if (ack_i) begin
         ack_i    = 1'b0;
         in_cycle = 1'b0;
      end else if (stb && cyc) begin
         if (!in_cycle) begin
            in_cycle  = 1'b1;
            wait_left = $urandom % 4;
         end
         if (wait_left == 0) begin
            if (we) begin
               for (int b = 0; b < 4; b++) begin
                  if (sel[b]) begin
                     mem[adr[7:2]][8*b +: 8] = wb_dat_o[8*b +: 8];
                  end
               end
            end else begin
               // Corrupt read-back flips the case bit
               wb_dat_i = corrupt ? (mem[adr[7:2]] ^ 32'h20) : mem[adr[7:2]];
            end
            ack_i = 1'b1;
         end else begin
            wait_left--;
         end
      end
   end

   // Run limit
   always @(posedge clk) begin
      cycles++;
      if (cycles >= limit) begin
         $display("Timeout: run did not finish within %0d cycles", limit);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   // Fields in order pressed, key, en, hold, rel, bus, adr, dat, lcd, rs, lcd data, corrupt
   task automatic load_steps();
      steps[0] = '{1'b0, 4'd0,  1'b1, 4'd2,  4'd1, 1'b0, 32'h0, 8'h00, 1'b0, 1'b0, 8'h00, 1'b0};
      steps[1] = '{1'b1, 4'd0,  1'b1, 4'd4,  4'd3, 1'b1, 32'h3000_0000, "1", 1'b1, 1'b1, "1", 1'b0};
      steps[2] = '{1'b1, 4'd5,  1'b1, 4'd4,  4'd3, 1'b1, 32'h3000_0004, "5", 1'b1, 1'b1, "5", 1'b0};
      // Long hold still gives one sequence
      steps[3] = '{1'b1, 4'd3,  1'b1, 4'd12, 4'd3, 1'b1, 32'h3000_0008, "A", 1'b1, 1'b1, "A", 1'b0};
      steps[4] = '{1'b1, 4'd9,  1'b1, 4'd4,  4'd3, 1'b1, 32'h3000_000C, "8", 1'b1, 1'b1, 8'h18, 1'b1};
      // Star key clears without bus traffic
      steps[5] = '{1'b1, 4'd12, 1'b1, 4'd4,  4'd3, 1'b0, 32'h0, 8'h00, 1'b1, 1'b0, 8'h01, 1'b0};
      steps[6] = '{1'b1, 4'd13, 1'b1, 4'd4,  4'd3, 1'b1, 32'h3000_0000, "0", 1'b1, 1'b1, "0", 1'b0};
      steps[7] = '{1'b1, 4'd6,  1'b0, 4'd6,  4'd3, 1'b0, 32'h0, 8'h00, 1'b0, 1'b0, 8'h00, 1'b0};
      steps[8] = '{1'b1, 4'd15, 1'b1, 4'd4,  4'd3, 1'b1, 32'h3000_0004, "D", 1'b1, 1'b1, "D", 1'b0};
      steps[9] = '{1'b1, 4'd14, 1'b1, 4'd4,  4'd3, 1'b1, 32'h3000_0008, "#", 1'b1, 1'b1, 8'h03, 1'b1};
   endtask

   initial begin
      clk          = 1'b0;
      rst_n_i      = 1'b0;
      en_i         = 1'b0;
      la_data_in   = '0;
      la_oenb      = '1;
      wb_dat_i     = '0;
      ack_i        = 1'b0;
      key_down     = 1'b0;
      held_key     = 4'd0;
      corrupt      = 1'b0;
      in_cycle     = 1'b0;
      wait_left    = 0;
      cycles       = 0;
      lcd_expected = 0;
      void'($urandom(29));
      for (int a = 0; a < 64; a++) begin
         mem[a] = 32'hC0DE_0000 ^ (32'(a) * 32'h0101_0101);
      end
      load_steps();
      limit = 200;
      for (int i = 0; i < NSTEP; i++) begin
         limit += (int'(steps[i].hold) + int'(steps[i].rel)) * 4 * SCAN;
      end

      repeat (4) @(posedge clk);
      #1;
      rst_n_i = 1'b1;

      for (int i = 0; i < NSTEP; i++) begin
         s    = steps[i];
         en_i = s.en;
         // Scanner settles on the new enable before the press
         next_cycle();
         corrupt = s.corrupt;
         if (s.has_bus) begin
            i_checker.push_bus(1'b1, s.adr, s.dat);
            i_checker.push_bus(1'b0, s.adr, 8'h00);
         end
         if (s.has_lcd) begin
            i_checker.push_lcd(s.rs, s.lcd);
            lcd_expected++;
         end
         held_key = s.key;
         key_down = s.pressed;
         repeat (int'(s.hold) * 4 * SCAN) next_cycle();
         key_down = 1'b0;
         repeat (int'(s.rel) * 4 * SCAN) next_cycle();
         // Sequence ends with the falling edge of LCD en
         while (lcd_count < lcd_expected) begin
            next_cycle();
         end
      end

      repeat (8) next_cycle();
      i_checker.final_check();
      $display("Run complete: %0d bus cycles, %0d LCD transfers, %0d errors",
         bus_count, lcd_count, err_count);
      if (err_count == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- src.f
team_01_pkg.sv
wishbone_manager.sv
keypad_scanner.sv
lcd_driver.sv
team_01_cpu.sv
team_01.sv
tb_checker.sv
tb_team_01.sv

//--- Makefile
# Verilator build and run for the team_01 testbench

SIM = obj_dir/Vtb_team_01

.PHONY: all run clean

all: run

$(SIM): src.f $(shell cat src.f)
	verilator --binary --timing --assert -f src.f --top-module tb_team_01 -o Vtb_team_01

# Passes only when the pass message shows up in the output
run: $(SIM)
	$(SIM) | awk '{ print } /\*\*\* TEST PASSED \*\*\*/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
